//--- tetris_display.f
src/tetris_display_pkg.sv
src/stage_delay.sv
src/vga_timing.sv
src/board_regs_apb.sv
src/grid_renderer.sv
src/tetris_display.sv
bench/tetris_display_asserts.sv
bench/tb_tetris_display.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the tetris_display testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_tetris_display \
    --Mdir "$OBJ" -o sim_tetris_display \
    -f tetris_display.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Let assertion errors through so the closing report still prints
"./$OBJ/sim_tetris_display" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- bench/tb_tetris_display.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tetris_display;

    localparam int FRAME_CLKS   = 800 * 525;   // Clocks per frame
    localparam int ACTIVE_CLKS  = 800 * 480;   // Frame start to end of last visible line
    // 11 vertical lines of 300 and 21 horizontal lines of 150 less their crossings
    localparam int LINE_PIXELS  = 11 * 300 + 21 * 150 - 11 * 21;
    localparam int TIMEOUT_CLKS = 3 * FRAME_CLKS + 10000;

    logic                         clk = 1'b0;
    logic                         reset;
    tetris_display_pkg::apb_req_t apb_req;
    tetris_display_pkg::apb_rsp_t apb_rsp;
    logic [2:0]                   rgb;
    logic                         hsync;
    logic                         vsync;

    logic [9:0] shadow_rows [20];   // Board as written by the host
    logic       shadow_gameover;
    int         edge_cnt     = 0;   // DUT clock edges since reset release
    int         cycle_cnt    = 0;
    int         pixel_errors = 0;
    int         reg_errors   = 0;
    int         frame_errors = 0;
    int         printed      = 0;
    int         seed         = 32'hb47c;

    tetris_display u_tetris_display (
        .clk     (clk),
        .reset   (reset),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .rgb     (rgb),
        .hsync   (hsync),
        .vsync   (vsync)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (!reset) begin
            edge_cnt <= edge_cnt + 1;
        end
        if (cycle_cnt == TIMEOUT_CLKS) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CLKS);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        if (printed < 50) begin
            $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
        end else if (printed == 50) begin
            $display("Too many mismatches, further ones are counted only");
        end
        printed++;
    endtask

    //////////////////////////////////////////////////
    // Pixel reference model
    //////////////////////////////////////////////////

    // Well spans x 245..394 and y 90..389 with 15 pixel cells
    function automatic logic [2:0] model_rgb(input int x, input int y);
        int dx;
        int dy;
        dx = x - 245;
        dy = y - 90;
        if (x >= 640 || y >= 480 || dx < 0 || dx >= 150 || dy < 0 || dy >= 300) begin
            return 3'b000;
        end
        if (dx % 15 == 0 || dy % 15 == 0 || dx == 149 || dy == 299) begin
            return shadow_gameover ? 3'b100 : 3'b111;  // Red grid after game over
        end
        return shadow_rows[dy / 15][dx / 15] ? 3'b111 : 3'b000;
    endfunction

    // Outputs trail the counters by two clocks
    always @(negedge clk) begin
        int   p;
        int   h;
        int   v;
        logic exp_h;
        logic exp_v;
        logic [2:0] exp_rgb;
        if (!reset && edge_cnt >= 2) begin
            p       = (edge_cnt - 2) % FRAME_CLKS;
            h       = p % 800;
            v       = p / 800;
            exp_rgb = model_rgb(h, v);
            exp_h   = !(h >= 656 && h < 752);
            exp_v   = !(v >= 490 && v < 492);
            if (rgb !== exp_rgb) begin
                report_mismatch("rgb", exp_rgb, rgb);
                pixel_errors++;
            end
            if (hsync !== exp_h) begin
                report_mismatch("hsync", exp_h, hsync);
                pixel_errors++;
            end
            if (vsync !== exp_v) begin
                report_mismatch("vsync", exp_v, vsync);
                pixel_errors++;
            end
        end
    end

    // Interior pixels of set cells
    // Last column and row lose one pixel to the edge line
    function automatic int filled_pixels();
        int total;
        total = 0;
        for (int r = 0; r < 20; r++) begin
            for (int c = 0; c < 10; c++) begin
                if (shadow_rows[r][c]) begin
                    total += (c == 9 ? 13 : 14) * (r == 19 ? 13 : 14);
                end
            end
        end
        return total;
    endfunction

    //////////////////////////////////////////////////
    // APB host
    //////////////////////////////////////////////////

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err);
        @(posedge clk);
        #1;
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clk);
        if (apb_rsp.pslverr !== exp_err) begin
            report_mismatch("pslverr", exp_err, apb_rsp.pslverr);
            reg_errors++;
        end
        @(posedge clk);  // Write lands here
        #1;
        apb_req = '0;
        if (!exp_err && addr == 8'h50) begin
            shadow_gameover = data[0];
        end else if (!exp_err) begin
            shadow_rows[addr[6:2]] = data[9:0];
        end
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp_data,
                            input logic exp_err);
        @(posedge clk);
        #1;
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clk);  // prdata settled mid access cycle
        if (apb_rsp.pslverr !== exp_err) begin
            report_mismatch("pslverr", exp_err, apb_rsp.pslverr);
            reg_errors++;
        end
        if (!exp_err && apb_rsp.prdata !== exp_data) begin
            report_mismatch("prdata", exp_data, apb_rsp.prdata);
            reg_errors++;
        end
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    //////////////////////////////////////////////////
    // Frame helpers and directed tests
    //////////////////////////////////////////////////

    task automatic wait_pixel(input int index);
        @(negedge clk);
        while (edge_cnt - 2 < index) begin
            @(negedge clk);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("** Error at %0t: %s count expected %0d, got %0d",
                     $time, name, exp, act);
            frame_errors++;
        end
    endtask

    // White and red pixels over the visible lines of one frame
    task automatic scan_frame(input int frame, output int white, output int red);
        white = 0;
        red   = 0;
        wait_pixel(frame * FRAME_CLKS);
        repeat (ACTIVE_CLKS) begin
            if (rgb == 3'b111) begin
                white++;
            end
            if (rgb == 3'b100) begin
                red++;
            end
            @(negedge clk);
        end
    endtask

    task automatic test_empty_board();
        int white;
        int red;
        scan_frame(0, white, red);
        check_count("white, empty board", LINE_PIXELS, white);
        check_count("red, empty board", 0, red);
    endtask

    task automatic test_registers();
        logic [31:0] pattern [20];
        logic [31:0] ctrl;
        for (int r = 0; r < 20; r++) begin
            pattern[r] = $random(seed);
            apb_write(8'(4 * r), pattern[r], 1'b0);
        end
        ctrl = $random(seed);
        apb_write(8'h50, ctrl, 1'b0);
        for (int r = 0; r < 20; r++) begin
            apb_read(8'(4 * r), {22'd0, pattern[r][9:0]}, 1'b0);  // Upper bits read zero
        end
        apb_read(8'h50, {31'd0, ctrl[0]}, 1'b0);
        // Accesses past the map or misaligned leave the registers alone
        apb_write(8'h54, {31'd0, ~ctrl[0]}, 1'b1);
        apb_write(8'h02, ~pattern[0], 1'b1);
        apb_read(8'h54, 32'd0, 1'b1);
        apb_read(8'h02, 32'd0, 1'b1);
        apb_read(8'h00, {22'd0, pattern[0][9:0]}, 1'b0);
        apb_read(8'h50, {31'd0, ctrl[0]}, 1'b0);
        apb_write(8'h50, 32'd0, 1'b0);  // Back to normal play
    endtask

    task automatic test_sync_timing();
        int width;
        int period;
        width  = 0;
        period = 0;
        do @(negedge clk); while (hsync !== 1'b1);
        do @(negedge clk); while (hsync !== 1'b0);
        do begin
            width++;
            @(negedge clk);
        end while (hsync === 1'b0);
        period = width;
        do begin
            period++;
            @(negedge clk);
        end while (hsync === 1'b1);
        check_count("hsync low clocks", 96, width);
        check_count("line clocks", 800, period);
        width = 0;
        do @(negedge clk); while (vsync !== 1'b0);
        do begin
            width++;
            @(negedge clk);
        end while (vsync === 1'b0);
        check_count("vsync low clocks", 2 * 800, width);
    endtask

    task automatic test_filled_cells();
        int white;
        int red;
        scan_frame(1, white, red);
        check_count("white, filled board", LINE_PIXELS + filled_pixels(), white);
        check_count("red, filled board", 0, red);
    endtask

    task automatic test_game_over();
        int white;
        int red;
        apb_write(8'h50, 32'd1, 1'b0);
        apb_read(8'h50, 32'd1, 1'b0);
        scan_frame(2, white, red);
        check_count("red, game over", LINE_PIXELS, red);
        check_count("white, game over", filled_pixels(), white);
    endtask

    initial begin
        int total;
        reset           = 1'b1;
        apb_req         = '0;
        shadow_gameover = 1'b0;
        for (int r = 0; r < 20; r++) begin
            shadow_rows[r] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        test_empty_board();
        test_registers();      // Runs in the vertical blanking of frame 0
        test_sync_timing();
        test_filled_cells();
        test_game_over();
        wait_pixel(3 * FRAME_CLKS);  // Finish frame 2 under the pixel monitor

        total = pixel_errors + reg_errors + frame_errors +
                int'(u_tetris_display.u_asserts.assert_failures);
        $display("Error counts: pixel %0d, register %0d, frame %0d, assertion %0d",
                 pixel_errors, reg_errors, frame_errors,
                 u_tetris_display.u_asserts.assert_failures);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/tetris_display_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module tetris_display_asserts (
    input wire logic                          clk,
    input wire logic                          reset,
    input wire tetris_display_pkg::apb_req_t  apb_req,
    input wire tetris_display_pkg::apb_rsp_t  apb_rsp,
    input wire logic [2:0]                    rgb,
    input wire logic                          hsync,
    input wire logic                          vsync,
    input wire tetris_display_pkg::vga_sync_t sync_dly
);

    int unsigned assert_failures = 0;  // Failed assertion tally

    // Zero wait state slave
    pready_high: assert property (@(posedge clk) disable iff (reset)
        apb_req.psel |-> apb_rsp.pready)
    else begin
        assert_failures++;
        $error("pready low while psel high");
    end

    pslverr_idle: assert property (@(posedge clk) disable iff (reset)
        !(apb_req.psel && apb_req.penable) |-> !apb_rsp.pslverr)
    else begin
        assert_failures++;
        $error("pslverr high outside an access cycle");
    end

    // Pulse started exactly 96 clocks before it ends
    hsync_width: assert property (@(posedge clk) disable iff (reset)
        $rose(hsync) |-> !$past(hsync, 96) && $past(hsync, 97))
    else begin
        assert_failures++;
        $error("hsync low pulse is not 96 clocks wide");
    end

    // Frame pulse starts at the line start, 48 clocks after the hsync pulse
    vsync_edge: assert property (@(posedge clk) disable iff (reset)
        $fell(vsync) |-> hsync && $past(hsync, 48) && !$past(hsync, 49))
    else begin
        assert_failures++;
        $error("vsync fell away from the start of a line");
    end

    blank_black: assert property (@(posedge clk) disable iff (reset)
        !sync_dly.active |-> rgb == tetris_display_pkg::COLOR_BLACK)
    else begin
        assert_failures++;
        $error("rgb not black during blanking");
    end

endmodule

bind tetris_display tetris_display_asserts u_asserts (
    .clk      (clk),
    .reset    (reset),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .rgb      (rgb),
    .hsync    (hsync),
    .vsync    (vsync),
    .sync_dly (sync_dly)
);

`default_nettype wire

//--- src/tetris_display.sv
`timescale 1ns/1ps
`default_nettype none

module tetris_display (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire tetris_display_pkg::apb_req_t  apb_req,
    output tetris_display_pkg::apb_rsp_t       apb_rsp,
    output logic [2:0]                         rgb,
    output logic                               hsync,
    output logic                               vsync
);

    tetris_display_pkg::board_t    board;
    logic                          gameover;
    tetris_display_pkg::vga_pos_t  pos;
    tetris_display_pkg::vga_sync_t sync_raw;   // Aligned with pos
    tetris_display_pkg::vga_sync_t sync_dly;   // Aligned with rgb

    //////////////////////////////////////////////////
    // Host side
    //////////////////////////////////////////////////

    board_regs_apb u_board_regs (
        .clk      (clk),
        .reset    (reset),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .board    (board),
        .gameover (gameover)
    );

    // Video side
    vga_timing u_vga_timing (
        .clk   (clk),
        .reset (reset),
        .pos   (pos),
        .sync  (sync_raw)
    );

    grid_renderer u_grid_renderer (
        .clk      (clk),
        .reset    (reset),
        .pos      (pos),
        .board    (board),
        .gameover (gameover),
        .rgb      (rgb)
    );

    // Match the renderer latency
    stage_delay #(
        .payload_t   (tetris_display_pkg::vga_sync_t),
        .DEPTH       (tetris_display_pkg::PIXEL_LATENCY),
        .RESET_VALUE (tetris_display_pkg::SYNC_IDLE)
    ) u_sync_delay (
        .clk   (clk),
        .reset (reset),
        .in    (sync_raw),
        .out   (sync_dly)
    );

    assign hsync = sync_dly.hsync;
    assign vsync = sync_dly.vsync;

endmodule

`default_nettype wire

//--- src/grid_renderer.sv
`timescale 1ns/1ps
`default_nettype none

module grid_renderer (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire tetris_display_pkg::vga_pos_t  pos,
    input  wire tetris_display_pkg::board_t    board,
    input  wire logic                          gameover,
    output logic [2:0]                         rgb
);

    logic [9:0]                     off_x;    // Offset from well corner
    logic [9:0]                     off_y;
    tetris_display_pkg::cell_info_t cell_d;
    tetris_display_pkg::cell_info_t cell_q;
    logic [2:0]                     color_d;

    //////////////////////////////////////////////////
    // Stage 1, position to cell
    //////////////////////////////////////////////////

    always_comb begin
        off_x = pos.x - tetris_display_pkg::GRID_X0;  // Wraps outside the well, masked below
        off_y = pos.y - tetris_display_pkg::GRID_Y0;

        cell_d.in_grid = (pos.x >= tetris_display_pkg::GRID_X0) &&
                         (pos.x <  tetris_display_pkg::GRID_X1) &&
                         (pos.y >= tetris_display_pkg::GRID_Y0) &&
                         (pos.y <  tetris_display_pkg::GRID_Y1);

        // Cell borders, plus the closing right and bottom edges
        cell_d.on_line = (off_x % tetris_display_pkg::BLOCK_SIZE == 10'd0) ||
                         (off_y % tetris_display_pkg::BLOCK_SIZE == 10'd0) ||
                         (pos.x == tetris_display_pkg::GRID_X1 - 10'd1) ||
                         (pos.y == tetris_display_pkg::GRID_Y1 - 10'd1);

        cell_d.row    = 5'(off_y / tetris_display_pkg::BLOCK_SIZE);
        cell_d.col    = 4'(off_x / tetris_display_pkg::BLOCK_SIZE);
        cell_d.active = pos.active;
    end

    stage_delay #(
        .payload_t   (tetris_display_pkg::cell_info_t),
        .DEPTH       (1),
        .RESET_VALUE (tetris_display_pkg::cell_info_t'(0))
    ) u_cell_reg (
        .clk   (clk),
        .reset (reset),
        .in    (cell_d),
        .out   (cell_q)
    );

    //////////////////////////////////////////////////
    // Stage 2, cell to colour
    //////////////////////////////////////////////////

    always_comb begin
        if (!cell_q.active || !cell_q.in_grid) begin
            color_d = tetris_display_pkg::COLOR_BLACK;  // Blanking or outside well
        end else if (cell_q.on_line) begin
            color_d = gameover ? tetris_display_pkg::COLOR_RED
                               : tetris_display_pkg::COLOR_WHITE;
        end else if (board[cell_q.row][cell_q.col]) begin
            color_d = tetris_display_pkg::COLOR_WHITE;  // Filled cell
        end else begin
            color_d = tetris_display_pkg::COLOR_BLACK;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rgb <= tetris_display_pkg::COLOR_BLACK;
        end else begin
            rgb <= color_d;
        end
    end

endmodule

`default_nettype wire

//--- src/board_regs_apb.sv
`timescale 1ns/1ps
`default_nettype none

module board_regs_apb (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire tetris_display_pkg::apb_req_t  apb_req,
    output tetris_display_pkg::apb_rsp_t       apb_rsp,
    output tetris_display_pkg::board_t         board,
    output logic                               gameover
);

    tetris_display_pkg::board_t rows_q;   // One register per playfield row
    logic                       gameover_q;

    logic                                          access;    // APB access phase
    logic                                          aligned;
    logic [tetris_display_pkg::APB_ADDR_W-1:0]     row_addr;  // Offset from row base
    logic [4:0]                                    row_idx;
    logic                                          is_row;
    logic                                          is_ctrl;
    logic                                          addr_ok;

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////

    always_comb begin
        access   = apb_req.psel && apb_req.penable;
        aligned  = (apb_req.paddr[1:0] == 2'b00);  // Word addresses only
        row_addr = apb_req.paddr - tetris_display_pkg::ROW_BASE;
        row_idx  = row_addr[6:2];
        is_row   = aligned &&
                   (row_addr[tetris_display_pkg::APB_ADDR_W-1:2] <
                    tetris_display_pkg::BOARD_ROWS);
        is_ctrl  = (apb_req.paddr == tetris_display_pkg::CTRL_ADDR);
        addr_ok  = is_row || is_ctrl;
    end

    // Write path, ignored on error
    always_ff @(posedge clk) begin
        if (reset) begin
            rows_q     <= '0;
            gameover_q <= 1'b0;
        end else if (access && apb_req.pwrite && addr_ok) begin
            if (is_row) begin
                // Only the column bits are stored
                rows_q[row_idx] <= apb_req.pwdata[tetris_display_pkg::BOARD_COLS-1:0];
            end else begin
                gameover_q <= apb_req.pwdata[0];
            end
        end
    end

    //////////////////////////////////////////////////
    // Read path and response
    //////////////////////////////////////////////////

    always_comb begin
        if (is_row) begin
            apb_rsp.prdata = 32'(rows_q[row_idx]);  // Upper bits zero
        end else if (is_ctrl) begin
            apb_rsp.prdata = {31'd0, gameover_q};
        end else begin
            apb_rsp.prdata = 32'd0;
        end
        apb_rsp.pready  = 1'b1;                 // No wait states
        apb_rsp.pslverr = access && !addr_ok;   // Unmapped or misaligned
    end

    assign board    = rows_q;
    assign gameover = gameover_q;

endmodule

`default_nettype wire

//--- src/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing (
    input  wire logic                          clk,
    input  wire logic                          reset,
    output tetris_display_pkg::vga_pos_t       pos,
    output tetris_display_pkg::vga_sync_t      sync
);

    logic [9:0] h_count;   // Pixel within line
    logic [9:0] v_count;   // Line within frame
    logic [9:0] h_next;
    logic [9:0] v_next;
    logic       hsync_q;
    logic       vsync_q;
    logic       active_q;

    //////////////////////////////////////////////////
    // Next counter values
    //////////////////////////////////////////////////

    always_comb begin
        h_next = h_count + 10'd1;
        v_next = v_count;
        if (h_count == tetris_display_pkg::H_TOTAL - 10'd1) begin
            h_next = 10'd0;  // End of line
            if (v_count == tetris_display_pkg::V_TOTAL - 10'd1) begin
                v_next = 10'd0;  // End of frame
            end else begin
                v_next = v_count + 10'd1;
            end
        end
    end

    // Decode from the next values so the flags
    // land in the same cycle as their counters
    always_ff @(posedge clk) begin
        if (reset) begin
            h_count  <= 10'd0;
            v_count  <= 10'd0;
            hsync_q  <= 1'b1;   // Position (0,0) lies outside both pulses
            vsync_q  <= 1'b1;
            active_q <= 1'b1;   // and inside the picture
        end else begin
            h_count  <= h_next;
            v_count  <= v_next;
            hsync_q  <= !((h_next >= tetris_display_pkg::H_SYNC_START) &&
                          (h_next <  tetris_display_pkg::H_SYNC_END));
            vsync_q  <= !((v_next >= tetris_display_pkg::V_SYNC_START) &&
                          (v_next <  tetris_display_pkg::V_SYNC_END));
            active_q <= (h_next < tetris_display_pkg::H_ACTIVE) &&
                        (v_next < tetris_display_pkg::V_ACTIVE);
        end
    end

    //////////////////////////////////////////////////
    // Outputs, all straight from registers
    //////////////////////////////////////////////////

    always_comb begin
        pos.x       = h_count;
        pos.y       = v_count;
        pos.active  = active_q;
        sync.hsync  = hsync_q;
        sync.vsync  = vsync_q;
        sync.active = active_q;  // Rides along with sync for blanking
    end

endmodule

`default_nettype wire

//--- src/stage_delay.sv
`timescale 1ns/1ps
`default_nettype none

module stage_delay #(
    parameter type      payload_t   = logic,
    parameter int       DEPTH       = 1,     // At least 1
    parameter payload_t RESET_VALUE = '0
) (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire payload_t in,
    output payload_t      out
);

    payload_t pipe [DEPTH];  // pipe[0] is the youngest

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= RESET_VALUE;
            end
        end else begin
            pipe[0] <= in;
            for (int i = 1; i < DEPTH; i++) begin
                pipe[i] <= pipe[i-1];  // Shift one stage per clock
            end
        end
    end

    assign out = pipe[DEPTH-1];

endmodule

`default_nettype wire

//--- src/tetris_display_pkg.sv
`default_nettype none

package tetris_display_pkg;

    //////////////////////////////////////////////////
    // Screen timing, 640x480 at one pixel per clock
    //////////////////////////////////////////////////

    localparam logic [9:0] H_ACTIVE = 10'd640;  // Visible pixels per line
    localparam logic [9:0] H_FRONT  = 10'd16;
    localparam logic [9:0] H_SYNC   = 10'd96;   // Sync pulse width
    localparam logic [9:0] H_TOTAL  = 10'd800;  // Clocks per line

    localparam logic [9:0] V_ACTIVE = 10'd480;  // Visible lines
    localparam logic [9:0] V_FRONT  = 10'd10;
    localparam logic [9:0] V_SYNC   = 10'd2;
    localparam logic [9:0] V_TOTAL  = 10'd525;  // Lines per frame

    // Sync windows, low for start <= count < end
    localparam logic [9:0] H_SYNC_START = H_ACTIVE + H_FRONT;      // 656
    localparam logic [9:0] H_SYNC_END   = H_SYNC_START + H_SYNC;   // 752
    localparam logic [9:0] V_SYNC_START = V_ACTIVE + V_FRONT;      // 490
    localparam logic [9:0] V_SYNC_END   = V_SYNC_START + V_SYNC;   // 492

    //////////////////////////////////////////////////
    // Well geometry
    //////////////////////////////////////////////////

    localparam int BOARD_COLS = 10;
    localparam int BOARD_ROWS = 20;

    localparam logic [9:0] GRID_X0    = 10'd245;  // Top-left corner of well
    localparam logic [9:0] GRID_Y0    = 10'd90;
    localparam logic [9:0] BLOCK_SIZE = 10'd15;   // Cell edge in pixels

    // First pixel past the well on each axis
    localparam logic [9:0] GRID_X1 = GRID_X0 + BLOCK_SIZE * 10'(BOARD_COLS);  // 395
    localparam logic [9:0] GRID_Y1 = GRID_Y0 + BLOCK_SIZE * 10'(BOARD_ROWS);  // 390

    // Colour codes and pipeline depth
    localparam logic [2:0] COLOR_BLACK = 3'b000;
    localparam logic [2:0] COLOR_WHITE = 3'b111;
    localparam logic [2:0] COLOR_RED   = 3'b100;

    localparam int PIXEL_LATENCY = 2;  // Position to colour, in clocks

    //////////////////////////////////////////////////
    // APB register map
    //////////////////////////////////////////////////

    localparam int APB_ADDR_W = 8;

    localparam logic [APB_ADDR_W-1:0] ROW_BASE  = 8'h00;  // Row r at ROW_BASE + 4*r
    localparam logic [APB_ADDR_W-1:0] CTRL_ADDR = 8'h50;  // Bit 0 is gameover

    // Shared types
    typedef logic [BOARD_ROWS-1:0][BOARD_COLS-1:0] board_t;  // [row][col]

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_ADDR_W-1:0] paddr;
        logic [31:0]           pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       active;  // Inside the visible area
    } vga_pos_t;

    typedef struct packed {
        logic hsync;   // Active low
        logic vsync;   // Active low
        logic active;
    } vga_sync_t;

    // Renderer stage-1 result
    typedef struct packed {
        logic       in_grid;
        logic       on_line;
        logic [4:0] row;
        logic [3:0] col;
        logic       active;
    } cell_info_t;

    // Sync lines idle high, picture blanked
    localparam vga_sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, active: 1'b0};

endpackage

`default_nettype wire
